/* include/cmd_consts.svh */
`ifndef CMD_CONSTS_SVH
`define CMD_CONSTS_SVH

// number of client streams
`define CMD_NUM_CHAN 4
// channel tag width, log2 of the client count
`define CMD_CHAN_W   2

// command word, same width as one accumulator
`define CMD_WORD_W   32

// op field at the top of every command word
`define CMD_OP_W     4
// immediate format field
`define CMD_IMM_W    28
// shift format field, low bits of the word
`define CMD_SHAMT_W  5

// unused bits between op and shamt in the shift view
`define CMD_PAD_W    (`CMD_WORD_W - `CMD_OP_W - `CMD_SHAMT_W)

`endif

/* src/cmd_pkg.sv */
`include "cmd_consts.svh"

package cmd_pkg;

  // one accumulator or operand
  typedef logic [`CMD_WORD_W-1:0] word_t;

  // 8 to 15 left unassigned, decoded as illegal
  typedef enum logic [`CMD_OP_W-1:0] {
    LOAD = 0,
    ADD  = 1,
    SUB  = 2,
    XOR  = 3,
    SHL  = 4,
    SHR  = 5,
    ROTL = 6,
    READ = 7
  } cmd_op_e;

  ////////////////////
  // command word views

  // immediate format
  typedef struct packed {
    cmd_op_e                 op;
    logic [`CMD_IMM_W-1:0]   imm;
  } cmd_imm_s;

  // shift format, pad bits ignored
  typedef struct packed {
    cmd_op_e                 op;
    logic [`CMD_PAD_W-1:0]   pad;
    logic [`CMD_SHAMT_W-1:0] shamt;
  } cmd_shift_s;

  typedef union packed {
    cmd_imm_s                imm;
    cmd_shift_s              shift;
  } cmd_word_u;

  ////////////////////
  // stage records

  // fan-in output, word tagged with its client
  typedef struct packed {
    logic [`CMD_CHAN_W-1:0]  chan;
    cmd_word_u               word;
  } tagged_cmd_s;

  // decode output
  typedef struct packed {
    logic [`CMD_CHAN_W-1:0]  chan;
    cmd_op_e                 op;
    word_t                   operand;
    logic                    illegal;
  } dec_op_s;

  // execute and result output
  typedef struct packed {
    logic [`CMD_CHAN_W-1:0]  chan;
    word_t                   value;
    logic                    err;
  } rsp_s;

endpackage

/* src/cmd_fan_in.sv */
`timescale 1ns/10ps
`include "cmd_consts.svh"

module cmd_fan_in (
  input  logic                                   clk,
  input  logic                                   rst,
  // client streams
  input  logic [`CMD_NUM_CHAN-1:0]               s_valid,
  output logic [`CMD_NUM_CHAN-1:0]               s_ready,
  input  cmd_pkg::cmd_word_u [`CMD_NUM_CHAN-1:0] s_word,
  // merged tagged stream
  output logic                                   fan_valid,
  input  logic                                   fan_ready,
  output cmd_pkg::tagged_cmd_s                   fan_cmd
);

  import cmd_pkg::*;

  localparam int NUM_CHAN = `CMD_NUM_CHAN;

  logic [NUM_CHAN-1:0]    chan_prio;
  logic [NUM_CHAN-1:0]    grant_q;
  logic [`CMD_CHAN_W-1:0] chan_num;
  logic                   hold_grant;
  logic                   accept;
  logic                   out_valid_q;
  tagged_cmd_s            out_q;

  ////////////////////
  // arbitration

  // channel n may win only if all lower channels are idle
  always_comb begin
    chan_prio[0] = 1'b1;
    for (int n = 1; n < NUM_CHAN; n++) begin
      chan_prio[n] = chan_prio[n-1] & ~s_valid[n-1];
    end
  end

  // lock while the granted client keeps valid up
  assign hold_grant = |(grant_q & s_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_q <= '0;
    end else if (!hold_grant) begin
      // lowest valid channel, or nobody
      grant_q <= s_valid & chan_prio;
    end
  end

  // one-hot grant to channel tag
  always_comb begin
    chan_num = '0;
    for (int n = 0; n < NUM_CHAN; n++) begin
      if (grant_q[n]) begin
        chan_num = chan_num | `CMD_CHAN_W'(n);
      end
    end
  end

  ////////////////////
  // client handshake

  // only the granted client sees ready, and only when downstream can take it
  assign s_ready = grant_q & {NUM_CHAN{fan_ready}};
  assign accept  = |(s_valid & s_ready);

  ////////////////////
  // output register

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q <= 1'b0;
    end else if (accept) begin
      out_valid_q <= 1'b1;
    end else if (fan_ready) begin
      out_valid_q <= 1'b0;
    end
  end

  // selected word with its tag
  always_ff @(posedge clk) begin
    if (accept) begin
      out_q.chan <= chan_num;
      out_q.word <= s_word[chan_num];
    end
  end

  assign fan_valid = out_valid_q;
  assign fan_cmd   = out_q;

  // lock and priority must never grant two clients at once
  a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant_q))
    else $error("fan-in grant is not one-hot: %b", grant_q);

endmodule

/* src/cmd_decode.sv */
`timescale 1ns/10ps

module cmd_decode (
  input  logic                 clk,
  input  logic                 rst,
  // tagged words from fan-in
  input  logic                 fan_valid,
  output logic                 fan_ready,
  input  cmd_pkg::tagged_cmd_s fan_cmd,
  // decoded operations to execute
  output logic                 dec_valid,
  input  logic                 dec_ready,
  output cmd_pkg::dec_op_s     dec_op
);

  import cmd_pkg::*;

  dec_op_s dec_d;
  dec_op_s dec_q;
  logic    dec_valid_q;
  logic    accept;

  ////////////////////
  // word decode

  // op sits in the same place in both views
  always_comb begin
    dec_d.chan    = fan_cmd.chan;
    dec_d.op      = fan_cmd.word.imm.op;
    dec_d.operand = '0;
    dec_d.illegal = 1'b0;
    case (fan_cmd.word.imm.op)
      LOAD, ADD, SUB, XOR: begin
        // immediate view
        dec_d.operand = word_t'(fan_cmd.word.imm.imm);
      end
      SHL, SHR, ROTL: begin
        // shift view, pad dropped
        dec_d.operand = word_t'(fan_cmd.word.shift.shamt);
      end
      READ: begin
        // fields ignored
        dec_d.operand = '0;
      end
      default: begin
        // 8 to 15
        dec_d.illegal = 1'b1;
      end
    endcase
  end

  ////////////////////
  // stage register

  // take a word when empty or when the held one leaves now
  assign fan_ready = ~dec_valid_q | dec_ready;
  assign accept    = fan_valid & fan_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid_q <= 1'b0;
    end else if (accept) begin
      dec_valid_q <= 1'b1;
    end else if (dec_ready) begin
      dec_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec_q <= dec_d;
    end
  end

  assign dec_valid = dec_valid_q;
  assign dec_op    = dec_q;

  // a stalled operation stays put until execute takes it
  a_dec_stable: assert property (@(posedge clk) disable iff (rst)
    dec_valid && !dec_ready |=> dec_valid && $stable(dec_op))
    else $error("decode output changed while stalled");

endmodule

/* src/cmd_execute.sv */
`timescale 1ns/10ps

module cmd_execute (
  input  logic             clk,
  input  logic             rst,
  // decoded operations
  input  logic             dec_valid,
  output logic             dec_ready,
  input  cmd_pkg::dec_op_s dec_op,
  // responses to the result stage
  output logic             exe_valid,
  input  logic             exe_ready,
  output cmd_pkg::rsp_s    exe_rsp
);

  import cmd_pkg::*;

  // sizes follow the operation record
  localparam int NUM_ACC = 1 << $bits(dec_op.chan);
  localparam int WORD_W  = $bits(word_t);
  localparam int SHAMT_W = $clog2(WORD_W);

  word_t                acc_q [NUM_ACC];
  word_t                acc_cur;
  word_t                acc_nxt;
  logic [SHAMT_W-1:0]   shamt;
  logic [2*WORD_W-1:0]  rot_dbl;
  logic                 accept;
  logic                 exe_valid_q;
  rsp_s                 rsp_q;

  ////////////////////
  // arithmetic and shift unit

  assign acc_cur = acc_q[dec_op.chan];
  assign shamt   = dec_op.operand[SHAMT_W-1:0];
  // rotate as the upper half of a doubled word
  assign rot_dbl = {acc_cur, acc_cur} << shamt;

  always_comb begin
    case (dec_op.op)
      LOAD:    acc_nxt = dec_op.operand;
      ADD:     acc_nxt = acc_cur + dec_op.operand;
      SUB:     acc_nxt = acc_cur - dec_op.operand;
      XOR:     acc_nxt = acc_cur ^ dec_op.operand;
      SHL:     acc_nxt = acc_cur << shamt;
      SHR:     acc_nxt = acc_cur >> shamt;
      ROTL:    acc_nxt = rot_dbl[2*WORD_W-1:WORD_W];
      // READ and illegal codes keep the value
      default: acc_nxt = acc_cur;
    endcase
  end

  ////////////////////
  // accumulator bank

  assign dec_ready = ~exe_valid_q | exe_ready;
  assign accept    = dec_valid & dec_ready;

  // written only on acceptance, so back-to-back words chain
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_ACC; i++) begin
        acc_q[i] <= '0;
      end
    end else if (accept && !dec_op.illegal) begin
      acc_q[dec_op.chan] <= acc_nxt;
    end
  end

  ////////////////////
  // response register

  always_ff @(posedge clk) begin
    if (rst) begin
      exe_valid_q <= 1'b0;
    end else if (accept) begin
      exe_valid_q <= 1'b1;
    end else if (exe_ready) begin
      exe_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_q.chan  <= dec_op.chan;
      rsp_q.value <= acc_nxt;
      rsp_q.err   <= dec_op.illegal;
    end
  end

  assign exe_valid = exe_valid_q;
  assign exe_rsp   = rsp_q;

endmodule

/* src/cmd_result.sv */
`timescale 1ns/10ps

module cmd_result (
  input  logic          clk,
  input  logic          rst,
  // responses from execute
  input  logic          exe_valid,
  output logic          exe_ready,
  input  cmd_pkg::rsp_s exe_rsp,
  // response stream out of the engine
  output logic          m_valid,
  input  logic          m_ready,
  output cmd_pkg::rsp_s m_rsp
);

  import cmd_pkg::*;

  rsp_s main_q;
  rsp_s skid_q;
  logic main_valid_q;
  logic skid_valid_q;
  logic skid_valid_d;
  logic ready_q;
  logic accept;
  logic main_free;

  assign accept    = exe_valid & ready_q;
  // main register empties or hands off this cycle
  assign main_free = ~main_valid_q | m_ready;

  // skid fills only when a word arrives behind a stalled main entry
  always_comb begin
    if (main_free) begin
      skid_valid_d = 1'b0;
    end else begin
      skid_valid_d = skid_valid_q | accept;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b1;
    end else begin
      if (main_free) begin
        main_valid_q <= skid_valid_q | accept;
      end
      skid_valid_q <= skid_valid_d;
      // upstream ready comes from a flop
      ready_q      <= ~skid_valid_d;
    end
  end

  ////////////////////
  // payload path

  // skid drains first, keeps order
  always_ff @(posedge clk) begin
    if (main_free && skid_valid_q) begin
      main_q <= skid_q;
    end else if (main_free && accept) begin
      main_q <= exe_rsp;
    end
    if (!main_free && accept) begin
      skid_q <= exe_rsp;
    end
  end

  assign exe_ready = ready_q;
  assign m_valid   = main_valid_q;
  assign m_rsp     = main_q;

  a_m_stable: assert property (@(posedge clk) disable iff (rst)
    m_valid && !m_ready |=> m_valid && $stable(m_rsp))
    else $error("response changed while stalled");

endmodule

/* src/cmd_engine_top.sv */
`timescale 1ns/10ps
`include "cmd_consts.svh"

module cmd_engine_top (
  input  logic                                   clk,
  input  logic                                   rst,
  // client command streams
  input  logic [`CMD_NUM_CHAN-1:0]               s_valid,
  output logic [`CMD_NUM_CHAN-1:0]               s_ready,
  input  cmd_pkg::cmd_word_u [`CMD_NUM_CHAN-1:0] s_word,
  // shared response stream
  output logic                                   m_valid,
  input  logic                                   m_ready,
  output cmd_pkg::rsp_s                          m_rsp
);

  import cmd_pkg::*;

  // fan-in to decode
  logic        fan_valid;
  logic        fan_ready;
  tagged_cmd_s fan_cmd;
  // decode to execute
  logic        dec_valid;
  logic        dec_ready;
  dec_op_s     dec_op;
  // execute to result
  logic        exe_valid;
  logic        exe_ready;
  rsp_s        exe_rsp;

  cmd_fan_in cmd_fan_in_i (
    .clk       (clk),
    .rst       (rst),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_word    (s_word),
    .fan_valid (fan_valid),
    .fan_ready (fan_ready),
    .fan_cmd   (fan_cmd)
  );

  cmd_decode cmd_decode_i (
    .clk       (clk),
    .rst       (rst),
    .fan_valid (fan_valid),
    .fan_ready (fan_ready),
    .fan_cmd   (fan_cmd),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_op    (dec_op)
  );

  cmd_execute cmd_execute_i (
    .clk       (clk),
    .rst       (rst),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_op    (dec_op),
    .exe_valid (exe_valid),
    .exe_ready (exe_ready),
    .exe_rsp   (exe_rsp)
  );

  // last stage, registered ready toward execute
  cmd_result cmd_result_i (
    .clk       (clk),
    .rst       (rst),
    .exe_valid (exe_valid),
    .exe_ready (exe_ready),
    .exe_rsp   (exe_rsp),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_rsp     (m_rsp)
  );

endmodule

/* dv/cmd_engine_tb.sv */
`timescale 1ns/10ps
`include "cmd_consts.svh"

module cmd_engine_tb;

  import cmd_pkg::*;

  localparam int NUM_CHAN     = `CMD_NUM_CHAN;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_TESTS    = 36;

  // one table row with name, stimulus and expected response
  typedef struct {
    string     name;
    int        chan;
    cmd_word_u word;
    rsp_s      exp;
  } test_entry_t;

  logic                          clk;
  logic                          rst;
  logic [NUM_CHAN-1:0]           s_valid;
  logic [NUM_CHAN-1:0]           s_ready;
  cmd_word_u [NUM_CHAN-1:0]      s_word;
  logic                          m_valid;
  logic                          m_ready;
  rsp_s                          m_rsp;

  test_entry_t tests [NUM_TESTS];
  int          n_added;
  word_t       model_acc [NUM_CHAN];
  // table indices still owed a response on each channel
  int          exp_q [NUM_CHAN][$];
  int          mismatch_count;
  int          other_errors;
  int          checked_count;
  logic [31:0] lcg_state;
  logic        stalled;
  rsp_s        stall_rsp;

  cmd_engine_top cmd_engine_top_i (
    .clk     (clk),
    .rst     (rst),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_word  (s_word),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_rsp   (m_rsp)
  );

  // 100 ns period
  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////
  // stimulus helpers

  function automatic cmd_word_u imm_word(input logic [3:0] op, input logic [27:0] imm);
    return {op, imm};
  endfunction

  // op, pad, shamt from top to bottom
  function automatic cmd_word_u shift_word(input logic [3:0] op,
                                           input logic [`CMD_PAD_W-1:0] pad,
                                           input logic [`CMD_SHAMT_W-1:0] shamt);
    return {op, pad, shamt};
  endfunction

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // reference rule for one command on one accumulator
  function automatic word_t model_step(input word_t acc, input logic [31:0] word,
                                       output logic err);
    logic [3:0] op;
    word_t      imm;
    int         sh;
    word_t      res;
    op  = word[31:28];
    imm = {4'h0, word[27:0]};
    sh  = word[4:0];
    err = 1'b0;
    res = acc;
    case (op)
      4'd0: res = imm;
      4'd1: res = acc + imm;
      4'd2: res = acc - imm;
      4'd3: res = acc ^ imm;
      4'd4: res = acc << sh;
      4'd5: res = acc >> sh;
      4'd6: res = (sh == 0) ? acc : ((acc << sh) | (acc >> (32 - sh)));
      4'd7: res = acc;
      // 8 to 15 keep the value
      default: err = 1'b1;
    endcase
    return res;
  endfunction

  task automatic add_test(input string name, input int chan, input cmd_word_u word);
    tests[n_added].name = name;
    tests[n_added].chan = chan;
    tests[n_added].word = word;
    n_added++;
  endtask

  task automatic build_table();
    logic e;
    int   c;
    n_added = 0;
    // immediate ops with carry and borrow
    add_test("ch0_read_reset",     0, imm_word(READ, 28'h0));
    add_test("ch0_load",           0, imm_word(LOAD, 28'hFFFFFFF));
    add_test("ch0_add",            0, imm_word(ADD,  28'h0000123));
    add_test("ch0_load_ones",      0, imm_word(LOAD, 28'hFFFFFFF));
    add_test("ch0_shl_4",          0, shift_word(SHL, 23'h0, 5'd4));
    add_test("ch0_add_carry",      0, imm_word(ADD,  28'h0000020));
    add_test("ch0_sub_below_zero", 0, imm_word(SUB,  28'h0000011));
    add_test("ch0_xor",            0, imm_word(XOR,  28'hA5A5A5A));
    add_test("ch0_read_end",       0, imm_word(READ, 28'h0));
    // shift view with pad bits set on purpose
    add_test("ch1_read_reset",     1, imm_word(READ, 28'h0));
    add_test("ch1_load",           1, imm_word(LOAD, 28'h8000003));
    add_test("ch1_shl_0_pad",      1, shift_word(SHL,  23'h7FFFFF, 5'd0));
    add_test("ch1_shl_1_pad",      1, shift_word(SHL,  23'h7FFFFF, 5'd1));
    add_test("ch1_shr_1",          1, shift_word(SHR,  23'h0,      5'd1));
    add_test("ch1_rotl_1_pad",     1, shift_word(ROTL, 23'h555555, 5'd1));
    add_test("ch1_rotl_31",        1, shift_word(ROTL, 23'h0,      5'd31));
    add_test("ch1_shr_0_pad",      1, shift_word(SHR,  23'h2AAAAA, 5'd0));
    add_test("ch1_shl_31",         1, shift_word(SHL,  23'h0,      5'd31));
    add_test("ch1_rotl_0_pad",     1, shift_word(ROTL, 23'h7FFFFF, 5'd0));
    add_test("ch1_shr_31_pad",     1, shift_word(SHR,  23'h400001, 5'd31));
    // read and illegal codes
    add_test("ch2_read_reset",     2, imm_word(READ, 28'h0));
    add_test("ch2_load",           2, imm_word(LOAD, 28'h1234567));
    add_test("ch2_read_fields",    2, imm_word(READ, 28'hFFFFFFF));
    add_test("ch2_illegal_8",      2, imm_word(4'd8,  28'h0000001));
    add_test("ch2_illegal_15",     2, imm_word(4'd15, 28'hFFFFFFF));
    add_test("ch2_illegal_11",     2, imm_word(4'd11, 28'h00000FF));
    add_test("ch2_read_after_ill", 2, imm_word(READ, 28'h0));
    add_test("ch2_add",            2, imm_word(ADD,  28'h0000001));
    add_test("ch2_illegal_12",     2, imm_word(4'd12, 28'h0));
    add_test("ch2_read_final",     2, imm_word(READ, 28'h0));
    // fourth client kept apart from the others
    add_test("ch3_read_reset",     3, imm_word(READ, 28'h0));
    add_test("ch3_load",           3, imm_word(LOAD, 28'h5555555));
    add_test("ch3_xor",            3, imm_word(XOR,  28'hFFFFFFF));
    add_test("ch3_sub_below_zero", 3, imm_word(SUB,  28'hAAAAAAB));
    add_test("ch3_rotl_5_pad",     3, shift_word(ROTL, 23'h2AAAAA, 5'd5));
    add_test("ch3_read_end",       3, imm_word(READ, 28'h0));
    // expected values in table order within each channel
    for (int k = 0; k < NUM_CHAN; k++) begin
      model_acc[k] = '0;
    end
    for (int i = 0; i < NUM_TESTS; i++) begin
      c = tests[i].chan;
      tests[i].exp.value = model_step(model_acc[c], tests[i].word, e);
      tests[i].exp.chan  = c[`CMD_CHAN_W-1:0];
      tests[i].exp.err   = e;
      model_acc[c]       = tests[i].exp.value;
      exp_q[c].push_back(i);
    end
  endtask

  // one client drives its own rows in order
  // valid drops for a cycle between words
  task automatic drive_channel(input int ch);
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (tests[i].chan == ch) begin
        @(negedge clk);
        s_valid[ch] = 1'b1;
        s_word[ch]  = tests[i].word;
        @(posedge clk);
        while (!s_ready[ch]) begin
          @(posedge clk);
        end
        @(negedge clk);
        s_valid[ch] = 1'b0;
      end
    end
  endtask

  ////////////////////
  // output checker

  always @(posedge clk) begin : watch_output
    int idx;
    int ch;
    if (rst) begin
      stalled = 1'b0;
    end else begin
      // held response must not move
      if (stalled) begin
        assert (m_valid && m_rsp == stall_rsp) else begin
          $display("response changed or vanished while m_ready was low");
          other_errors++;
        end
      end
      stalled   = m_valid && !m_ready;
      stall_rsp = m_rsp;
      if (m_valid && m_ready) begin
        ch = m_rsp.chan;
        checked_count++;
        assert (exp_q[ch].size() != 0) else begin
          $display("response on channel %0d with nothing outstanding", ch);
          other_errors++;
        end
        if (exp_q[ch].size() != 0) begin
          idx = exp_q[ch].pop_front();
          assert (m_rsp == tests[idx].exp) else begin
            $display("Mismatch %s: expected ch %0d val %h err %b, actual ch %0d val %h err %b",
                     tests[idx].name, tests[idx].exp.chan, tests[idx].exp.value,
                     tests[idx].exp.err, m_rsp.chan, m_rsp.value, m_rsp.err);
            mismatch_count++;
          end
        end
      end
    end
  end

  // random back-pressure with ready about three cycles in four
  initial begin : drive_ready
    logic [31:0] r;
    @(negedge clk);
    forever begin
      r       = next_rand();
      m_ready = (r[17:16] != 2'b00);
      @(negedge clk);
    end
  end

  // run limit scales with the table
  initial begin : watchdog
    repeat (RESET_CYCLES + 40 * NUM_TESTS) @(posedge clk);
    $display("timeout: %0d of %0d responses arrived, %0d mismatch, %0d other errors",
             checked_count, NUM_TESTS, mismatch_count, other_errors);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////
  // main sequence

  initial begin : main_seq
    rst            = 1'b1;
    s_valid        = '0;
    s_word         = '0;
    m_ready        = 1'b0;
    lcg_state      = 32'd60;
    mismatch_count = 0;
    other_errors   = 0;
    checked_count  = 0;
    stalled        = 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (m_valid == 1'b0 && s_ready == '0) else begin
      $display("m_valid or s_ready high right after reset");
      other_errors++;
    end
    // all four clients start on the same edge
    fork
      drive_channel(0);
      drive_channel(1);
      drive_channel(2);
      drive_channel(3);
    join
    wait (checked_count == NUM_TESTS);
    // room for any stray extra response
    repeat (20) @(posedge clk);
    for (int k = 0; k < NUM_CHAN; k++) begin
      assert (exp_q[k].size() == 0) else begin
        $display("channel %0d still owes %0d responses", k, exp_q[k].size());
        other_errors++;
      end
    end
    $display("errors: %0d mismatch, %0d other, %0d of %0d responses checked",
             mismatch_count, other_errors, checked_count, NUM_TESTS);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+include
src/cmd_pkg.sv
src/cmd_fan_in.sv
src/cmd_decode.sv
src/cmd_execute.sv
src/cmd_result.sv
src/cmd_engine_top.sv
dv/cmd_engine_tb.sv

/* Bender.yml */
package:
  name: cmd_engine

export_include_dirs:
  - include

sources:
  - files:
      - src/cmd_pkg.sv
      - src/cmd_fan_in.sv
      - src/cmd_decode.sv
      - src/cmd_execute.sv
      - src/cmd_result.sv
      - src/cmd_engine_top.sv
  - target: test
    files:
      - dv/cmd_engine_tb.sv
